//--- include/spi_ctl_macros.svh
// frame length, register width and peripheral count
// register bank addresses for the spi control block

`ifndef SPI_CTL_MACROS_SVH
`define SPI_CTL_MACROS_SVH

//////////////////////////////////////////////////
// frame and register sizes

// bits per spi frame, address byte then value byte
`define FRAME_BITS 16

// width of each control register
`define REG_BITS 4

// downstream spi peripherals behind the mux
`define PERIPH_COUNT 4

//////////////////////////////////////////////////
// register addresses

`define ADDR_LED          8'd7
`define ADDR_MUX          8'd8
`define ADDR_DAC          8'd9
`define ADDR_RAILS        8'd10
`define ADDR_SOFT_RESET   8'd11
`define ADDR_DAC_REF_MUX  8'd12
// 13 unused, decoded as unknown
`define ADDR_ADC          8'd14
`define ADDR_CLAMP1       8'd15
`define ADDR_CLAMP2       8'd16
`define ADDR_RELAY_COM    8'd17

`endif

//--- rtl/reg_bank_execute.sv
// control register bank
// set, clear, toggle and soft reset, plus the readback word

`include "spi_ctl_macros.svh"

module reg_bank_execute import spi_ctl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  reg_cmd_t               cmd,
  input  logic                   cmd_valid,
  output ctl_regs_t              regs,
  output logic [`FRAME_BITS-1:0] readback
);

  ctl_regs_t            regs_next;
  logic [7:0]           last_addr;
  reg_sel_e             last_sel;
  logic [`REG_BITS-1:0] last_val;

  // new value of one field
  function automatic logic [`REG_BITS-1:0] apply_op(input logic [`REG_BITS-1:0] old,
                                                    input reg_cmd_t c);
    if (c.op == OP_TOGGLE)
      return old ^ c.set_mask;
    else
      return (old | c.set_mask) & ~c.clr_mask;
  endfunction

  //////////////////////////////////////////////////
  // next register file

  always_comb
  begin
    regs_next = regs;
    if (cmd_valid)
    begin
      case (cmd.op)
        OP_SET_CLEAR, OP_TOGGLE:
        begin
          case (cmd.sel)
            SEL_LED:         regs_next.led         = apply_op(regs.led, cmd);
            SEL_MUX:         regs_next.mux         = apply_op(regs.mux, cmd);
            SEL_DAC:         regs_next.dac         = apply_op(regs.dac, cmd);
            SEL_RAILS:       regs_next.rails       = apply_op(regs.rails, cmd);
            SEL_DAC_REF_MUX: regs_next.dac_ref_mux = apply_op(regs.dac_ref_mux, cmd);
            SEL_ADC:         regs_next.adc         = apply_op(regs.adc, cmd);
            SEL_CLAMP1:      regs_next.clamp1      = apply_op(regs.clamp1, cmd);
            SEL_CLAMP2:      regs_next.clamp2      = apply_op(regs.clamp2, cmd);
            SEL_RELAY_COM:   regs_next.relay_com   = apply_op(regs.relay_com, cmd);
            default:         regs_next = regs;
          endcase
        end
        // clamps and relay com survive a soft reset
        OP_SOFT_RESET:
        begin
          regs_next.led         = '0;
          regs_next.mux         = '0;
          regs_next.dac         = '0;
          regs_next.rails       = '0;
          regs_next.dac_ref_mux = '0;
          regs_next.adc         = '0;
        end
        default: regs_next = regs;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regs      <= '0;
      last_addr <= '0;
      last_sel  <= SEL_NONE;
    end
    else
    begin
      regs <= regs_next;
      // remember the last accepted command for readback
      if (cmd_valid)
      begin
        last_addr <= cmd.addr;
        last_sel  <= cmd.sel;
      end
    end
  end

  //////////////////////////////////////////////////
  // readback, current value of the last register

  always_comb
  begin
    case (last_sel)
      SEL_LED:         last_val = regs.led;
      SEL_MUX:         last_val = regs.mux;
      SEL_DAC:         last_val = regs.dac;
      SEL_RAILS:       last_val = regs.rails;
      SEL_DAC_REF_MUX: last_val = regs.dac_ref_mux;
      SEL_ADC:         last_val = regs.adc;
      SEL_CLAMP1:      last_val = regs.clamp1;
      SEL_CLAMP2:      last_val = regs.clamp2;
      SEL_RELAY_COM:   last_val = regs.relay_com;
      // soft reset or nothing yet
      default:         last_val = '0;
    endcase
  end

  assign readback = {last_addr, {(`FRAME_BITS - 8 - `REG_BITS){1'b0}}, last_val};

endmodule

//--- rtl/reg_cmd_decode.sv
// frame to command decoder
// address to register select, value to set and clear masks

`include "spi_ctl_macros.svh"

module reg_cmd_decode import spi_ctl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  spi_frame_t frame,
  input  logic       frame_valid,
  output reg_cmd_t   cmd,
  output logic       cmd_valid
);

  logic [`REG_BITS-1:0] set_bits;
  logic [`REG_BITS-1:0] clr_bits;
  logic [`REG_BITS-1:0] overlap;
  reg_cmd_t             cmd_next;

  // low nibble sets, high nibble clears
  assign set_bits = frame.val[`REG_BITS-1:0];
  assign clr_bits = frame.val[2*`REG_BITS-1:`REG_BITS];
  assign overlap  = set_bits & clr_bits;

  always_comb
  begin
    cmd_next.addr     = frame.addr;
    cmd_next.op       = OP_SET_CLEAR;
    cmd_next.sel      = SEL_NONE;
    cmd_next.set_mask = set_bits;
    cmd_next.clr_mask = clr_bits;

    // any bit both set and cleared makes the frame a toggle
    if (overlap != '0)
    begin
      cmd_next.op       = OP_TOGGLE;
      cmd_next.set_mask = overlap;
      cmd_next.clr_mask = overlap;
    end

    case (frame.addr)
      `ADDR_LED:         cmd_next.sel = SEL_LED;
      `ADDR_MUX:         cmd_next.sel = SEL_MUX;
      `ADDR_DAC:         cmd_next.sel = SEL_DAC;
      `ADDR_RAILS:       cmd_next.sel = SEL_RAILS;
      `ADDR_DAC_REF_MUX: cmd_next.sel = SEL_DAC_REF_MUX;
      `ADDR_ADC:         cmd_next.sel = SEL_ADC;
      `ADDR_CLAMP1:      cmd_next.sel = SEL_CLAMP1;
      `ADDR_CLAMP2:      cmd_next.sel = SEL_CLAMP2;
      `ADDR_RELAY_COM:   cmd_next.sel = SEL_RELAY_COM;
      // value byte ignored
      `ADDR_SOFT_RESET:  cmd_next.op  = OP_SOFT_RESET;
      // 13 and everything else
      default:           cmd_next.op  = OP_NONE;
    endcase
  end

  // strobe withheld for unknown addresses
  always_ff @(posedge clk)
  begin
    if (reset)
      cmd_valid <= 1'b0;
    else
      cmd_valid <= frame_valid && cmd_next.op != OP_NONE;
  end

  always_ff @(posedge clk)
  begin
    if (frame_valid)
      cmd <= cmd_next;
  end

endmodule

//--- rtl/spi_ctl_pkg.sv
// shared types for the spi control block
// frame, command and register file structs, opcode and select enums

`include "spi_ctl_macros.svh"

package spi_ctl_pkg;

  //////////////////////////////////////////////////
  // spi frame as received

  // address byte goes out first, so it sits in the high byte
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] val;
  } spi_frame_t;

  //////////////////////////////////////////////////
  // decoded command

  typedef enum logic [1:0] {
    OP_NONE       = 2'd0,
    OP_SET_CLEAR  = 2'd1,
    OP_TOGGLE     = 2'd2,
    OP_SOFT_RESET = 2'd3
  } reg_op_e;

  // one select per control register
  typedef enum logic [3:0] {
    SEL_LED         = 4'd0,
    SEL_MUX         = 4'd1,
    SEL_DAC         = 4'd2,
    SEL_RAILS       = 4'd3,
    SEL_DAC_REF_MUX = 4'd4,
    SEL_ADC         = 4'd5,
    SEL_CLAMP1      = 4'd6,
    SEL_CLAMP2      = 4'd7,
    SEL_RELAY_COM   = 4'd8,
    SEL_NONE        = 4'd15
  } reg_sel_e;

  // 22 bits; for toggle both masks carry the overlap
  typedef struct packed {
    reg_op_e               op;
    reg_sel_e              sel;
    logic [7:0]            addr;
    logic [`REG_BITS-1:0]  set_mask;
    logic [`REG_BITS-1:0]  clr_mask;
  } reg_cmd_t;

  //////////////////////////////////////////////////
  // control register file, 36 bits

  typedef struct packed {
    logic [`REG_BITS-1:0] led;
    logic [`REG_BITS-1:0] mux;
    logic [`REG_BITS-1:0] dac;
    logic [`REG_BITS-1:0] rails;
    logic [`REG_BITS-1:0] dac_ref_mux;
    logic [`REG_BITS-1:0] adc;
    logic [`REG_BITS-1:0] clamp1;
    logic [`REG_BITS-1:0] clamp2;
    logic [`REG_BITS-1:0] relay_com;
  } ctl_regs_t;

endpackage

//--- rtl/spi_ctl_top.sv
// spi board-control top level
// receiver, command decoder, register bank and router

`include "spi_ctl_macros.svh"

module spi_ctl_top import spi_ctl_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  // spi from the controller, raw
  input  logic                     sclk,
  input  logic                     cs_n,
  input  logic                     mosi,
  input  logic                     special_n,
  output logic                     miso,
  // downstream peripherals
  input  logic [`PERIPH_COUNT-1:0] periph_miso,
  output logic [`PERIPH_COUNT-1:0] periph_cs_n,
  // board control lines
  output ctl_regs_t                regs
);

  logic                   cs_n_sync;
  logic                   special_n_sync;
  spi_frame_t             frame;
  logic                   frame_valid;
  logic                   bank_miso;
  reg_cmd_t               cmd;
  logic                   cmd_valid;
  logic [`FRAME_BITS-1:0] readback;

  //////////////////////////////////////////////////
  // frame in, readback out

  spi_frame_rx u_rx (
    .clk            (clk),
    .reset          (reset),
    .sclk           (sclk),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .special_n      (special_n),
    .readback       (readback),
    .cs_n_sync      (cs_n_sync),
    .special_n_sync (special_n_sync),
    .frame          (frame),
    .frame_valid    (frame_valid),
    .bank_miso      (bank_miso)
  );

  //////////////////////////////////////////////////
  // decode and execute

  reg_cmd_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid)
  );

  reg_bank_execute u_execute (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .regs      (regs),
    .readback  (readback)
  );

  //////////////////////////////////////////////////
  // pass-through routing

  // mux register is one select bit per peripheral
  spi_route_result u_route (
    .mux_sel        (regs.mux),
    .cs_n_sync      (cs_n_sync),
    .special_n_sync (special_n_sync),
    .bank_miso      (bank_miso),
    .periph_miso    (periph_miso),
    .miso           (miso),
    .periph_cs_n    (periph_cs_n)
  );

endmodule

//--- rtl/spi_frame_rx.sv
// spi pin synchronizer and frame receiver
// shifts mosi into a frame, shifts readback out on bank_miso

`include "spi_ctl_macros.svh"

module spi_frame_rx import spi_ctl_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sclk,
  input  logic                   cs_n,
  input  logic                   mosi,
  input  logic                   special_n,
  input  logic [`FRAME_BITS-1:0] readback,
  output logic                   cs_n_sync,
  output logic                   special_n_sync,
  output spi_frame_t             frame,
  output logic                   frame_valid,
  output logic                   bank_miso
);

  // one extra bit so that more than 16 rises is seen as a bad frame
  localparam int CNT_BITS = $clog2(`FRAME_BITS) + 1;

  // raw pins, kept together through both sync stages
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic special_n;
  } spi_pins_t;

  // idle bus, deselected
  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, special_n: 1'b1};

  spi_pins_t              pin_meta;
  spi_pins_t              pin_sync;
  logic                   sclk_prev;
  logic                   cs_n_prev;
  logic                   sclk_rise;
  logic                   sclk_fall;
  logic                   cs_rise;
  logic                   cs_fall;
  logic                   bank_sel;
  logic [CNT_BITS-1:0]    bit_count;
  logic [`FRAME_BITS-1:0] rx_sr;
  logic [`FRAME_BITS-1:0] tx_sr;

  //////////////////////////////////////////////////
  // two-flop sync, edge history

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pin_meta  <= PINS_IDLE;
      pin_sync  <= PINS_IDLE;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
    end
    else
    begin
      pin_meta  <= '{sclk: sclk, cs_n: cs_n, mosi: mosi, special_n: special_n};
      pin_sync  <= pin_meta;
      sclk_prev <= pin_sync.sclk;
      cs_n_prev <= pin_sync.cs_n;
    end
  end

  assign sclk_rise = pin_sync.sclk & ~sclk_prev;
  assign sclk_fall = ~pin_sync.sclk & sclk_prev;
  assign cs_rise   = pin_sync.cs_n & ~cs_n_prev;
  assign cs_fall   = ~pin_sync.cs_n & cs_n_prev;
  // bank frame: both selects asserted
  assign bank_sel  = ~pin_sync.cs_n & ~pin_sync.special_n;

  assign cs_n_sync      = pin_sync.cs_n;
  assign special_n_sync = pin_sync.special_n;

  //////////////////////////////////////////////////
  // receive path

  // bit counter, restarts on cs fall, saturates
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (cs_fall)
      bit_count <= '0;
    else if (sclk_rise && bank_sel && bit_count != {CNT_BITS{1'b1}})
      bit_count <= bit_count + 1'b1;
  end

  // msb first, d into lsb
  always_ff @(posedge clk)
  begin
    if (sclk_rise && bank_sel)
      rx_sr <= {rx_sr[`FRAME_BITS-2:0], pin_sync.mosi};
  end

  assign frame = rx_sr;

  // accept only a complete bank frame
  always_ff @(posedge clk)
  begin
    if (reset)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && !pin_sync.special_n &&
                     bit_count == CNT_BITS'(`FRAME_BITS);
  end

  //////////////////////////////////////////////////
  // readback path

  // first bit ready before the first rise, rest move on falls
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_sr     <= '0;
      bank_miso <= 1'b0;
    end
    else if (cs_fall && !pin_sync.special_n)
    begin
      bank_miso <= readback[`FRAME_BITS-1];
      tx_sr     <= {readback[`FRAME_BITS-2:0], 1'b0};
    end
    else if (sclk_fall && bank_sel)
    begin
      bank_miso <= tx_sr[`FRAME_BITS-1];
      tx_sr     <= {tx_sr[`FRAME_BITS-2:0], 1'b0};
    end
  end

endmodule

//--- rtl/spi_route_result.sv
// peripheral chip-select decode and miso select
// bank readback or the muxed peripheral miso

`include "spi_ctl_macros.svh"

module spi_route_result (
  input  logic [`PERIPH_COUNT-1:0] mux_sel,
  input  logic                     cs_n_sync,
  input  logic                     special_n_sync,
  input  logic                     bank_miso,
  input  logic [`PERIPH_COUNT-1:0] periph_miso,
  output logic                     miso,
  output logic [`PERIPH_COUNT-1:0] periph_cs_n
);

  logic pass_sel;

  // pass-through only while the bank itself is not addressed
  assign pass_sel = ~cs_n_sync & special_n_sync;

  //////////////////////////////////////////////////
  // chip selects

  // all high unless passing through, then only mux bits go low
  always_comb
  begin
    for (int i = 0; i < `PERIPH_COUNT; i++)
      periph_cs_n[i] = ~(pass_sel & mux_sel[i]);
  end

  //////////////////////////////////////////////////
  // miso

  // mux mask keeps unselected peripherals off the line
  always_comb
  begin
    if (!special_n_sync)
      miso = bank_miso;
    else
      miso = |(periph_miso & mux_sel);
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the spi control testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module spi_ctl_tb -f spi_ctl.f -o spi_ctl_sim

output=$(./obj_dir/spi_ctl_sim)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
  exit 0
else
  exit 1
fi

//--- spi_ctl.f
+incdir+include
rtl/spi_ctl_pkg.sv
rtl/spi_frame_rx.sv
rtl/reg_cmd_decode.sv
rtl/reg_bank_execute.sv
rtl/spi_route_result.sv
rtl/spi_ctl_top.sv
test/spi_ctl_assertions.sv
test/spi_ctl_tb.sv

//--- test/spi_ctl_assertions.sv
// concurrent checks on the frame and command strobes
// and on peripheral chip-select routing

`include "spi_ctl_macros.svh"

module spi_ctl_assertions (
  input logic                     clk,
  input logic                     reset,
  input logic                     frame_valid,
  input logic                     cmd_valid,
  input logic [`PERIPH_COUNT-1:0] mux_sel,
  input logic                     special_n_sync,
  input logic [`PERIPH_COUNT-1:0] periph_cs_n
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // strobes

  // command one cycle behind its frame
  cmd_after_frame: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> $past(frame_valid))
    else $error("cmd_valid without frame_valid one cycle earlier");

  //////////////////////////////////////////////////
  // chip selects

  // at most one peripheral selected for a one-hot or empty mux
  cs_exclusive: assert property (@(posedge clk) disable iff (reset)
    ($countones(mux_sel) <= 1) |-> ($countones(~periph_cs_n) <= 1))
    else $error("more than one periph_cs_n low");

  // bank access keeps every peripheral deselected
  cs_idle_bank: assert property (@(posedge clk) disable iff (reset)
    !special_n_sync |-> periph_cs_n == '1)
    else $error("periph_cs_n low while special_n_sync low");

endmodule

// top level sees both strobes and the router outputs
bind spi_ctl_top spi_ctl_assertions u_assertions (
  .clk            (clk),
  .reset          (reset),
  .frame_valid    (frame_valid),
  .cmd_valid      (cmd_valid),
  .mux_sel        (regs.mux),
  .special_n_sync (special_n_sync),
  .periph_cs_n    (periph_cs_n)
);

//--- test/spi_ctl_tb.sv
// spi control block testbench
// clock, reset, spi frame driver, pass-through stimulus
// register model and checks against the data file

`include "spi_ctl_macros.svh"

module spi_ctl_tb
  import spi_ctl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // sclk half period in clk cycles
  localparam int HALF_PERIOD   = 4;
  localparam int SETTLE_CYCLES = 10;
  localparam int MAX_CYCLES    = 20000;
  localparam int MAX_LINES     = 200;
  localparam logic [31:0] LFSR_SEED = 32'hb040_15fb;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     sclk;
  logic                     cs_n;
  logic                     mosi;
  logic                     special_n;
  logic [`PERIPH_COUNT-1:0] periph_miso;
  logic                     miso;
  logic [`PERIPH_COUNT-1:0] periph_cs_n;
  ctl_regs_t                regs;

  int          errors;
  int          checks;
  // model register file, led in the top nibble
  logic [35:0] model_regs;
  logic [7:0]  model_last_addr;
  int          model_last_idx;
  logic [31:0] lfsr_state;

  always #20 clk = ~clk;

  spi_ctl_top DUT (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .miso        (miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .regs        (regs)
  );

  //////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [35:0] got,
                             input logic [35:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int k = 0; k < n; k++)
      @(posedge clk);
  endtask

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  //////////////////////////////////////////////////
  // register model

  // field position in the register file, -1 when none
  function automatic int field_index(input logic [7:0] addr);
    case (addr)
      `ADDR_LED:         return 0;
      `ADDR_MUX:         return 1;
      `ADDR_DAC:         return 2;
      `ADDR_RAILS:       return 3;
      `ADDR_DAC_REF_MUX: return 4;
      `ADDR_ADC:         return 5;
      `ADDR_CLAMP1:      return 6;
      `ADDR_CLAMP2:      return 7;
      `ADDR_RELAY_COM:   return 8;
      default:           return -1;
    endcase
  endfunction

  // last accepted address, value of that field in the low nibble
  function automatic logic [15:0] readback_model();
    logic [3:0] nib;
    nib = 4'h0;
    if (model_last_idx >= 0)
      nib = model_regs[35-4*model_last_idx -: 4];
    return {model_last_addr, 4'h0, nib};
  endfunction

  task automatic apply_frame_model(input logic [7:0] addr, input logic [7:0] val);
    int         idx;
    logic [3:0] set_bits;
    logic [3:0] clr_bits;
    logic [3:0] old;
    idx      = field_index(addr);
    set_bits = val[3:0];
    clr_bits = val[7:4];
    old      = 4'h0;
    if (addr == `ADDR_SOFT_RESET)
    begin
      // led down to adc cleared, clamps and relay kept
      model_regs[35:12] = '0;
      model_last_addr   = addr;
      model_last_idx    = -1;
    end
    else if (idx >= 0)
    begin
      old = model_regs[35-4*idx -: 4];
      // both set and cleared means toggle
      if ((set_bits & clr_bits) != 4'h0)
        model_regs[35-4*idx -: 4] = old ^ (set_bits & clr_bits);
      else
        model_regs[35-4*idx -: 4] = (old | set_bits) & ~clr_bits;
      model_last_addr = addr;
      model_last_idx  = idx;
    end
  endtask

  //////////////////////////////////////////////////
  // spi driver

  // mode 0, mosi moves with sclk low, miso taken just before each rise
  task automatic send_frame(input logic [15:0] word, input int nbits,
                            output logic [15:0] rx_bits);
    rx_bits = '0;
    @(posedge clk);
    special_n <= 1'b0;
    @(posedge clk);
    cs_n <= 1'b0;
    wait_cycles(2);
    for (int i = 0; i < nbits; i++)
    begin
      sclk <= 1'b0;
      mosi <= word[15-i];
      wait_cycles(HALF_PERIOD - 1);
      @(negedge clk);
      rx_bits[15-i] = miso;
      @(posedge clk);
      sclk <= 1'b1;
      wait_cycles(HALF_PERIOD);
    end
    sclk <= 1'b0;
    wait_cycles(HALF_PERIOD);
    cs_n <= 1'b1;
  endtask

  // count frame strobes while the pipeline drains
  task automatic settle_frame(output int pulses);
    pulses = 0;
    for (int k = 0; k < SETTLE_CYCLES; k++)
    begin
      @(negedge clk);
      if (DUT.frame_valid)
        pulses++;
    end
  endtask

  // chip select held low with random peripheral miso
  task automatic run_passthrough(input logic level, input logic [7:0] count);
    logic [3:0] pm;
    logic [3:0] mux;
    logic [3:0] exp_cs;
    logic       exp_miso;
    logic [15:0] rb;
    mux = model_regs[31:28];
    rb  = readback_model();
    pm  = 4'h0;
    @(posedge clk);
    special_n <= level;
    @(posedge clk);
    cs_n <= 1'b0;
    for (int s = 0; s < int'(count); s++)
    begin
      for (int b = 0; b < 4; b++)
      begin
        pm[b]      = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
      @(posedge clk);
      periph_miso <= pm;
      // pins reach the router after the two sync flops
      wait_cycles(2);
      @(negedge clk);
      if (level)
      begin
        exp_cs   = ~mux;
        exp_miso = |(pm & mux);
      end
      else
      begin
        // bank side: first readback bit, no peripheral selected
        exp_cs   = 4'hf;
        exp_miso = rb[15];
      end
      check_value("periph_cs_n", 36'(periph_cs_n), 36'(exp_cs));
      check_value("miso", 36'(miso), 36'(exp_miso));
    end
    @(posedge clk);
    cs_n        <= 1'b1;
    periph_miso <= '0;
    @(posedge clk);
    special_n <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // one line of the data file

  task automatic run_line(input byte kind, input logic [7:0] addr, input logic [7:0] val,
                          input logic [35:0] exp_regs, input logic [15:0] exp_rb);
    logic [15:0] rb_before;
    logic [15:0] rx_bits;
    logic [15:0] mask;
    int          nbits;
    int          pulses;
    int          expect_accept;
    rb_before     = readback_model();
    expect_accept = 0;
    rx_bits       = '0;
    check_value("readback model vs data file", 36'(rb_before), 36'(exp_rb));
    if (kind == "F" || kind == "S")
    begin
      nbits = (kind == "S") ? 12 : 16;
      send_frame({addr, val}, nbits, rx_bits);
      // short frames only see the leading bits
      mask = 16'hffff << (16 - nbits);
      check_value("bank_miso", 36'(rx_bits & mask), 36'(rb_before & mask));
      if (kind == "F")
      begin
        expect_accept = 1;
        apply_frame_model(addr, val);
      end
    end
    else if (kind == "P")
      run_passthrough(addr[0], val);
    else
    begin
      errors++;
      $display("unknown line kind %c in the data file", kind);
    end
    settle_frame(pulses);
    check_value("frame_valid pulses", 36'(pulses), 36'(expect_accept));
    check_value("regs", 36'(regs), model_regs);
    check_value("regs model vs data file", model_regs, exp_regs);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    int          fd;
    int          code;
    int          n;
    int          lines;
    string       line;
    byte         kind;
    logic [7:0]  addr;
    logic [7:0]  val;
    logic [35:0] exp_regs;
    logic [15:0] exp_rb;
    errors          = 0;
    checks          = 0;
    lines           = 0;
    model_regs      = '0;
    model_last_addr = '0;
    model_last_idx  = -1;
    lfsr_state      = LFSR_SEED;
    reset       <= 1'b1;
    sclk        <= 1'b0;
    cs_n        <= 1'b1;
    mosi        <= 1'b0;
    special_n   <= 1'b1;
    periph_miso <= '0;
    wait_cycles(2);
    reset <= 1'b0;
    wait_cycles(2);
    @(negedge clk);
    // idle state out of reset
    check_value("regs", 36'(regs), 36'h0);
    check_value("periph_cs_n", 36'(periph_cs_n), 36'hf);
    check_value("miso", 36'(miso), 36'h0);
    fd = $fopen("test/spi_ctl_testdata.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open test/spi_ctl_testdata.txt");
    end
    else
    begin
      while (!$feof(fd) && lines < MAX_LINES)
      begin
        code = $fgets(line, fd);
        lines++;
        if (code > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%c %h %h %h %h", kind, addr, val, exp_regs, exp_rb);
          // blank lines give fewer fields
          if (n == 5)
            run_line(kind, addr, val, exp_regs, exp_rb);
        end
      end
      $fclose(fd);
    end
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // watchdog
  initial
  begin
    for (int c = 0; c < MAX_CYCLES; c++)
      @(posedge clk);
    $display("timeout: simulation still running after %0d cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- test/spi_ctl_testdata.txt
# kind addr val regs readback, all hex; F bank frame, S 12-bit short frame, P pass-through
# regs nibbles: led mux dac rails dac_ref_mux adc clamp1 clamp2 relay_com; readback seen on miso
# P lines: addr is the special_n level, val the number of random periph_miso samples
F 07 05 500000000 0000
F 08 01 510000000 0705
F 09 0C 51C000000 0801
F 0A 03 51C300000 090C
F 0C 0F 51C3F0000 0A03
F 0E 09 51C3F9000 0C0F
F 0F 06 51C3F9600 0E09
F 10 0A 51C3F96A0 0F06
F 11 07 51C3F96A7 100A
F 07 40 11C3F96A7 1107
F 09 48 1183F96A7 0701
F 0A 33 1180F96A7 0908
F 0F 5A 1180F9AA7 0A00
F 11 F3 1180F9AA4 0F0A
F 0D 0F 1180F9AA4 1104
F 2A 05 1180F9AA4 1104
S 07 0F 1180F9AA4 1104
F 08 F0 1080F9AA4 1104
F 08 02 1280F9AA4 0800
P 01 08 1280F9AA4 0802
F 08 24 1480F9AA4 0802
P 01 08 1480F9AA4 0804
P 00 04 1480F9AA4 0804
F 0B 00 000000AA4 0804
F 0F 00 000000AA4 0B00
F 08 08 080000AA4 0F0A
P 01 08 080000AA4 0808
